// File: project.f
+incdir+source
source/core_pkg.sv
source/regbank.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/int_pipeline.sv
test/tb_int_pipeline.sv

// File: test/tb_int_pipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module tb_int_pipeline;

    localparam int ISSUE_CYCLES = 3000;
    localparam int CYCLE_LIMIT  = ISSUE_CYCLES + 50; // reset plus drain slack.

    logic                  clk;
    logic                  reset_n;
    logic [`CORE_XLEN-1:0] instr;
    logic                  instr_valid;
    core_pkg::retire_t     retire;

    logic [`CORE_XLEN-1:0] model_regs [`CORE_NREGS]; // architectural state.
    core_pkg::retire_t     exp_q [$]; // expected retires, oldest first.
    int                    due_q [$]; // cycle each item must show up.
    logic [31:0]           rng_state;
    int                    cycle;     // negedges since reset release.
    int                    wd_cycles; // posedges since time zero.
    int                    err_value;
    int                    err_timing;
    int                    err_missing;
    int                    err_unexpected;

    int_pipeline dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // hard stop if the run never reaches its end.
    always @(posedge clk) begin
        wd_cycles = wd_cycles + 1;
        if (wd_cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // xorshift32.
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // small register set, so hazards come often.
    function automatic logic [4:0] pick_reg(input logic [4:0] x);
        return {x[2], x[2], x[2], x[1:0]}; // x0..x3 and x28..x31.
    endfunction

    // funct3 of each test op number.
    function automatic logic [2:0] funct3_of(input int op);
        case (op)
            2:       return 3'b001; // sll.
            3:       return 3'b010; // slt.
            4:       return 3'b011; // sltu.
            5:       return 3'b100; // xor.
            6, 7:    return 3'b101; // srl, sra.
            8:       return 3'b110; // or.
            9:       return 3'b111; // and.
            default: return 3'b000; // add, sub.
        endcase
    endfunction

    // reference results, straight from the isa rules.
    function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return sa >>> b[4:0]; // sign fill.
            8:       return a | b;
            9:       return a & b;
            default: return b; // lui.
        endcase
    endfunction

    // one of five illegal encodings.
    function automatic logic [31:0] illegal_word(input logic [31:0] r);
        logic [2:0] f3;
        case (r[9:8])
            2'd0:    f3 = 3'b001;
            2'd1:    f3 = 3'b010;
            2'd2:    f3 = 3'b100;
            default: f3 = 3'b111;
        endcase // never add/sub or shift right.
        case (r[30:28] % 5)
            0:       return {r[31:7], 7'b0000011}; // load, not executed here.
            1:       return {7'h01, r[24:7], `OPC_OP}; // funct7 neither 0 nor 32.
            2:       return {7'h20, r[24:15], f3, r[11:7], `OPC_OP};
            3:       return {7'h20, r[24:15], 3'b001, r[11:7], `OPC_OP_IMM}; // bad slli.
            default: return {7'h10, r[24:15], 3'b101, r[11:7], `OPC_OP_IMM};
        endcase
    endfunction

    // build one word, predict its retire, update the model at once.
    task automatic issue_one();
        logic [31:0]       r;
        logic [31:0]       imm_r;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [6:0]        f7;
        logic [11:0]       imm12;
        int                op;
        core_pkg::retire_t exp;
        r         = next_rand();
        imm_r     = next_rand();
        rd        = pick_reg(r[4:0]);
        rs1       = pick_reg(r[9:5]);
        rs2       = pick_reg(r[14:10]);
        op        = r[19:16] % 10;
        exp       = '0;
        exp.valid = 1'b1;
        if (r[23:20] == 4'd0) begin // about 1 in 16.
            instr       = illegal_word(imm_r);
            exp.illegal = 1'b1;
            exp.rd      = instr[11:7]; // value stays zero.
        end else begin
            exp.rd = rd;
            case (r[25:24])
                2'd0, 2'd1: begin
                    f7        = (op == 1 || op == 7) ? 7'h20 : 7'h00;
                    instr     = {f7, rs2, rs1, funct3_of(op), rd, `OPC_OP};
                    exp.value = alu_model(op, model_regs[rs1], model_regs[rs2]);
                end
                2'd2: begin
                    if (op == 1)
                        op = 0; // no subi.
                    if (op == 2 || op == 6 || op == 7)
                        imm12 = {(op == 7) ? 7'h20 : 7'h00, imm_r[4:0]};
                    else
                        imm12 = imm_r[11:0];
                    instr     = {imm12, rs1, funct3_of(op), rd, `OPC_OP_IMM};
                    exp.value = alu_model(op, model_regs[rs1], {{20{imm12[11]}}, imm12});
                end
                default: begin
                    instr     = {imm_r[19:0], rd, `OPC_LUI};
                    exp.value = alu_model(10, 32'd0, {imm_r[19:0], 12'b0});
                end
            endcase
            if (rd != 5'd0)
                model_regs[rd] = exp.value; // x0 keeps zero.
        end
        instr_valid = 1'b1;
        exp_q.push_back(exp);
        due_q.push_back(cycle + 2); // two cycles of latency.
    endtask

    // compare the output against the head of the queue.
    task automatic check_retire();
        core_pkg::retire_t exp;
        int                due;
        if (retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected retire at %0t: rd %0d value %h with nothing in flight",
                         $time, retire.rd, retire.value);
                err_unexpected++;
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) begin
                    $display("mismatch at %0t: retired in cycle %0d, expected cycle %0d",
                             $time, cycle, due);
                    err_timing++;
                end
                if (retire !== exp) begin
                    $display("mismatch at %0t: got ill %b rd %0d value %h, exp ill %b rd %0d value %h",
                             $time, retire.illegal, retire.rd, retire.value,
                             exp.illegal, exp.rd, exp.value);
                    err_value++;
                end
            end
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            $display("missing retire at %0t: item due in cycle %0d never retired",
                     $time, due_q[0]);
            err_missing++;
            exp = exp_q.pop_front(); // drop it and move on.
            due = due_q.pop_front();
        end
    endtask

    // one falling edge: check first, then drive.
    task automatic step(input logic issue);
        logic [31:0] r;
        @(negedge clk);
        cycle++;
        check_retire();
        r = next_rand();
        if (issue && r[2:0] != 3'd0) begin
            issue_one();
        end else begin
            instr_valid = 1'b0; // bubble, about 1 in 8.
            instr       = r;    // junk word, must be ignored.
        end
    endtask

    initial begin
        int total;
        rng_state      = 32'h74528735;
        reset_n        = 1'b0;
        instr          = '0;
        instr_valid    = 1'b0;
        cycle          = 0;
        wd_cycles      = 0;
        err_value      = 0;
        err_timing     = 0;
        err_missing    = 0;
        err_unexpected = 0;
        for (int i = 0; i < `CORE_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) step(1'b0); // idle, nothing may retire yet.
        repeat (ISSUE_CYCLES) step(1'b1);
        while (exp_q.size() != 0) begin
            step(1'b0); // drain.
        end
        repeat (3) step(1'b0); // stray retires would show here.
        total = err_value + err_timing + err_missing + err_unexpected;
        $display("errors: value %0d, timing %0d, missing %0d, unexpected %0d",
                 err_value, err_timing, err_missing, err_unexpected);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/int_pipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module int_pipeline (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`CORE_XLEN-1:0]   instr,
    input  logic                    instr_valid, // one word per edge.
    output core_pkg::retire_t       retire
);

    logic [`CORE_REGW-1:0]  rs1;
    logic [`CORE_REGW-1:0]  rs2;
    logic [`CORE_XLEN-1:0]  rs1_data; // bank read, before forwarding.
    logic [`CORE_XLEN-1:0]  rs2_data;
    logic                   bank_we;
    core_pkg::decoded_t     dec;
    core_pkg::fwd_t         ex_fwd;

    // legal retires write the bank; x0 filtered inside.
    assign bank_we = retire.valid && !retire.illegal;

    decode_stage u_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ex_fwd      (ex_fwd),
        .retire      (retire),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec         (dec)
    );

    execute_stage u_execute (
        .clk     (clk),
        .reset_n (reset_n),
        .dec     (dec),
        .ex_fwd  (ex_fwd),
        .retire  (retire)
    );

    // bank beside the stages, written from retire.
    regbank u_regbank (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (retire.rd),
        .enable  (bank_we),
        .data    (retire.value),
        .data1   (rs1_data),
        .data2   (rs2_data)
    );

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  core_pkg::decoded_t  dec,
    output core_pkg::fwd_t      ex_fwd,
    output core_pkg::retire_t   retire
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  writes_reg; // item will really update a register.

    // a is always rs1; b is imm or rs2.
    assign op_a = dec.rs1_val;
    assign op_b = dec.use_imm ? dec.imm : dec.rs2_val;

    alu u_alu (
        .op     (dec.op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    assign writes_reg = dec.valid && !dec.illegal && dec.rd != '0;

    // live result back to decode, same cycle.
    always_comb begin
        ex_fwd       = '0;
        ex_fwd.valid = writes_reg;
        ex_fwd.rd    = dec.rd;
        ex_fwd.value = alu_result;
    end

    // retire register, second pipeline cycle.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            retire <= '0;
        end else begin
            retire.valid   <= dec.valid;
            retire.illegal <= dec.illegal;
            retire.rd      <= dec.rd;
            retire.value   <= dec.illegal ? '0 : alu_result; // illegal reports zero.
        end
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`CORE_XLEN-1:0]   instr,
    input  logic                    instr_valid,
    input  core_pkg::fwd_t          ex_fwd,
    input  core_pkg::retire_t       retire,
    output logic [`CORE_REGW-1:0]   rs1,
    output logic [`CORE_REGW-1:0]   rs2,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_XLEN-1:0]   rs2_data,
    output core_pkg::decoded_t      dec
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`CORE_REGW-1:0]  rd;
    logic [`CORE_XLEN-1:0]  imm_i; // sign-extended i form.
    logic [`CORE_XLEN-1:0]  imm_u; // upper 20 bits, low zeros.
    core_pkg::decoded_t     dec_next;

    // raw instruction fields.
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20]; // imm bits on i form, read is harmless.
    assign funct7 = instr[31:25];

    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // operand source by priority: execute, then retire, then bank.
    function automatic logic [`CORE_XLEN-1:0] pick_operand(
        input logic [`CORE_REGW-1:0] idx,
        input logic [`CORE_XLEN-1:0] bank_val,
        input core_pkg::fwd_t        ex,
        input core_pkg::retire_t     rt
    );
        if (idx == '0)
            return '0; // x0 reads zero always.
        if (ex.valid && ex.rd == idx)
            return ex.value; // live alu result.
        if (rt.valid && !rt.illegal && rt.rd == idx)
            return rt.value; // write lands this edge.
        return bank_val;
    endfunction

    always_comb begin
        dec_next         = '0;
        dec_next.valid   = instr_valid; // gaps flow down as bubbles.
        dec_next.rd      = rd;
        dec_next.rs1_val = pick_operand(rs1, rs1_data, ex_fwd, retire);
        dec_next.rs2_val = pick_operand(rs2, rs2_data, ex_fwd, retire);
        dec_next.op      = core_pkg::alu_add;
        case (opcode)
            `OPC_OP: begin
                case (funct3)
                    3'b000: dec_next.op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
                    3'b001: dec_next.op = core_pkg::alu_sll;
                    3'b010: dec_next.op = core_pkg::alu_slt;
                    3'b011: dec_next.op = core_pkg::alu_sltu;
                    3'b100: dec_next.op = core_pkg::alu_xor;
                    3'b101: dec_next.op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                    3'b110: dec_next.op = core_pkg::alu_or;
                    3'b111: dec_next.op = core_pkg::alu_and;
                endcase
                // only 0 and 32 exist, and 32 only on sub and sra.
                if (funct7 != 7'h00 && funct7 != 7'h20)
                    dec_next.illegal = 1'b1;
                else if (funct7 == 7'h20 && funct3 != 3'b000 && funct3 != 3'b101)
                    dec_next.illegal = 1'b1;
            end
            `OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_i; // shamt sits in imm[4:0].
                case (funct3)
                    3'b000: dec_next.op = core_pkg::alu_add;
                    3'b001: dec_next.op = core_pkg::alu_sll;
                    3'b010: dec_next.op = core_pkg::alu_slt;
                    3'b011: dec_next.op = core_pkg::alu_sltu;
                    3'b100: dec_next.op = core_pkg::alu_xor;
                    3'b101: dec_next.op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                    3'b110: dec_next.op = core_pkg::alu_or;
                    3'b111: dec_next.op = core_pkg::alu_and;
                endcase
                if (funct3 == 3'b001 && funct7 != 7'h00)
                    dec_next.illegal = 1'b1; // slli takes no funct7.
                else if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20)
                    dec_next.illegal = 1'b1; // srli or srai only.
            end
            `OPC_LUI: begin
                dec_next.op      = core_pkg::alu_pass_b;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_u;
            end
            default: dec_next.illegal = 1'b1; // unknown major opcode.
        endcase
    end

    // decode register, one cycle.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            dec <= '0;
        else
            dec <= dec_next;
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module alu (
    input  core_pkg::alu_op_e       op,
    input  logic [`CORE_XLEN-1:0]   a,
    input  logic [`CORE_XLEN-1:0]   b,
    output logic [`CORE_XLEN-1:0]   result
);

    logic [4:0] shamt;     // low bits of b only.
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            core_pkg::alu_add: begin
                result = a + b;
            end
            core_pkg::alu_sub: begin
                result = a - b;
            end
            core_pkg::alu_sll: begin
                result = a << shamt;
            end
            core_pkg::alu_slt: begin
                result = {{(`CORE_XLEN-1){1'b0}}, lt_signed}; // 1 or 0.
            end
            core_pkg::alu_sltu: begin
                result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            end
            core_pkg::alu_xor: begin
                result = a ^ b;
            end
            core_pkg::alu_srl: begin
                result = a >> shamt; // zero fill.
            end
            core_pkg::alu_sra: begin
                result = $unsigned($signed(a) >>> shamt); // sign fill.
            end
            core_pkg::alu_or: begin
                result = a | b;
            end
            core_pkg::alu_and: begin
                result = a & b;
            end
            core_pkg::alu_pass_b: begin
                result = b; // lui.
            end
            default: begin
                result = '0; // unused encodings.
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/regbank.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module regbank (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`CORE_REGW-1:0]   rs1,
    input  logic [`CORE_REGW-1:0]   rs2,
    input  logic [`CORE_REGW-1:0]   rd,
    input  logic                    enable,
    input  logic [`CORE_XLEN-1:0]   data,
    output logic [`CORE_XLEN-1:0]   data1,
    output logic [`CORE_XLEN-1:0]   data2
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS]; // x0 never written.

    // both read ports are plain muxes, no bypass here.
    assign data1 = regs[rs1];
    assign data2 = regs[rs2];

    // write on the edge; x0 stays zero from reset.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0; // all registers cleared.
            end
        end else if (enable && rd != '0) begin
            regs[rd] <= data;
        end
    end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none
`include "core_consts.svh"

package core_pkg;

    // alu operations, as chosen by the decoder.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // lui path, b goes straight through.
    } alu_op_e;

    // bundle from decode to execute.
    typedef struct packed {
        logic                   valid;
        logic                   illegal; // retire without write.
        alu_op_e                op;
        logic                   use_imm; // b operand from imm.
        logic [`CORE_REGW-1:0]  rd;
        logic [`CORE_XLEN-1:0]  rs1_val; // already forwarded.
        logic [`CORE_XLEN-1:0]  rs2_val;
        logic [`CORE_XLEN-1:0]  imm;
    } decoded_t;

    // retired result, also the bank write port.
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`CORE_REGW-1:0]  rd;
        logic [`CORE_XLEN-1:0]  value; // zero when illegal.
    } retire_t;

    // one forwarding source.
    typedef struct packed {
        logic                   valid; // only for a real write.
        logic [`CORE_REGW-1:0]  rd;
        logic [`CORE_XLEN-1:0]  value;
    } fwd_t;

endpackage

`default_nettype wire

// File: source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath width of the integer core.
`define CORE_XLEN 32

// architectural register file size.
`define CORE_NREGS 32

// bits needed to index one register.
`define CORE_REGW 5

// major opcodes, bits [6:0] of the instruction word.
`define OPC_OP      7'b0110011 // register-register alu.
`define OPC_OP_IMM  7'b0010011 // register-immediate alu.
`define OPC_LUI     7'b0110111 // load upper immediate.

`endif
